// File: regfile_ecc.f
verilog/p_regfile.sv
verilog/secded_encode.sv
verilog/secded_check.sv
verilog/rf_array.sv
verilog/acm.sv
verilog/regfile_ecc.sv
tb/tb_clock_gen.sv
tb/regfile_ecc_sva.sv
tb/regfile_ecc_tb.sv

// File: tb/regfile_ecc_sva.sv
// acm assertions
`timescale 1ns/1ps
`default_nettype none

module regfile_ecc_sva (
   input logic               s_clk_i,
   input logic               rst_n_i,
   input logic               wb_we_i,
   input p_regfile::rf_add_t wb_add_i,
   input logic               rd1_ce_i,
   input logic               rd2_ce_i,
   input logic               rd1_uce_i,
   input logic               rd2_uce_i,
   input logic               rep_pend_i,   // pending repair flag
   input p_regfile::rf_add_t rep_add_i     // register waiting for its repair
);

   // one kind of error per port at most
   a_port1_excl : assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      !(rd1_ce_i && rd1_uce_i))
      else $error("read port 1 flags ce and uce together");

   a_port2_excl : assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      !(rd2_ce_i && rd2_uce_i))
      else $error("read port 2 flags ce and uce together");

   // writeback owns the array port, the repair waits untouched
   a_wb_first : assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      rep_pend_i && wb_we_i && (wb_add_i != rep_add_i)
      |=> rep_pend_i && $stable(rep_add_i))
      else $error("pending repair consumed or changed while writeback was busy");

   // no repair survives a reset
   a_rst_pend : assert property (@(posedge s_clk_i) !rst_n_i |=> !rep_pend_i)
      else $error("pending repair set in the cycle after reset");

endmodule

bind acm regfile_ecc_sva m_sva (
   .s_clk_i    (s_clk_i),
   .rst_n_i    (rst_n_i),
   .wb_we_i    (wb_we_i),
   .wb_add_i   (wb_add_i),
   .rd1_ce_i   (rd1_ce_o),
   .rd2_ce_i   (rd2_ce_o),
   .rd1_uce_i  (rd1_uce_o),
   .rd2_uce_i  (rd2_uce_o),
   .rep_pend_i (rep_pend_q),
   .rep_add_i  (rep_add_q)
);

`default_nettype wire

// File: tb/regfile_ecc_tb.sv
// register file testbench
`timescale 1ns/1ps
`default_nettype none

module regfile_ecc_tb;

   localparam int N_RAND      = 200;   // random write/read cycles
   localparam int N_SCEN      = 6;     // rounds of the directed scenarios
   localparam int SCEN_CYC    = 50;    // upper bound of cycles per round
   localparam int TEST_CYCLES = 5 + p_regfile::NREGS + N_RAND + N_SCEN * SCEN_CYC;
   localparam int LIMIT_NS    = TEST_CYCLES * 4 + 400;   // 4 ns period plus margin

   logic               clk;
   logic               rst_n;
   logic               wb_we;
   p_regfile::rf_add_t wb_add;
   p_regfile::rf_val_t wb_val;
   logic               ma_we;
   p_regfile::rf_add_t ma_add;
   logic               ex_we;
   p_regfile::rf_add_t ex_add;
   p_regfile::rf_add_t rd1_add;
   p_regfile::rf_add_t rd2_add;
   p_regfile::rf_val_t rd1_val;
   p_regfile::rf_val_t rd2_val;
   logic               rd1_ce;
   logic               rd2_ce;
   logic               rd1_uce;
   logic               rd2_uce;
   logic               inj_we;
   p_regfile::rf_add_t inj_add;
   p_regfile::rf_val_t inj_dmask;
   p_regfile::rf_chk_t inj_cmask;

   p_regfile::rf_val_t ref_val [p_regfile::NREGS];   // true register contents
   p_regfile::rf_val_t ref_dm  [p_regfile::NREGS];   // data bits flipped so far
   p_regfile::rf_chk_t ref_cm  [p_regfile::NREGS];   // checksum bits flipped so far
   logic               ref_pend;                     // model of the pending repair
   p_regfile::rf_add_t ref_rep_add;
   logic [31:0]        lfsr;
   int                 n_chk;
   int                 n_err;

   tb_clock_gen #(.PERIOD_NS(4), .RST_CYCLES(5)) m_clk (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   regfile_ecc regfile_ecc_i (
      .s_clk_i         (clk),
      .rst_n_i         (rst_n),
      .wb_we_i         (wb_we),
      .wb_add_i        (wb_add),
      .wb_val_i        (wb_val),
      .ma_we_i         (ma_we),
      .ma_add_i        (ma_add),
      .ex_we_i         (ex_we),
      .ex_add_i        (ex_add),
      .rd1_add_i       (rd1_add),
      .rd2_add_i       (rd2_add),
      .rd1_val_o       (rd1_val),
      .rd2_val_o       (rd2_val),
      .rd1_ce_o        (rd1_ce),
      .rd2_ce_o        (rd2_ce),
      .rd1_uce_o       (rd1_uce),
      .rd2_uce_o       (rd2_uce),
      .inj_we_i        (inj_we),
      .inj_add_i       (inj_add),
      .inj_data_mask_i (inj_dmask),
      .inj_chk_mask_i  (inj_cmask)
   );

   // galois lfsr, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);   // one step per bit
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic p_regfile::rf_add_t rand_reg();   // never x0
      p_regfile::rf_add_t a;
      a = p_regfile::rf_add_t'(rand_bits(5));
      return (a == '0) ? 5'd1 : a;
   endfunction

   function automatic int nbits(input p_regfile::rf_add_t a);
      return $countones(ref_dm[a]) + $countones(ref_cm[a]);
   endfunction

   // operand is produced by a younger instruction
   function automatic logic is_fwd(input p_regfile::rf_add_t a);
      return (ex_we && ex_add == a) || (ma_we && ma_add == a) || (wb_we && wb_add == a);
   endfunction

   function automatic logic ce_expected(input p_regfile::rf_add_t a);
      return (a != '0) && (nbits(a) == 1) && !is_fwd(a);
   endfunction

   // array gets written at a on the coming edge
   function automatic logic file_hit(input p_regfile::rf_add_t a);
      return (wb_we && wb_add != '0 && wb_add == a) || (!wb_we && ref_pend && ref_rep_add == a);
   endfunction

   task automatic check_port(input string name, input p_regfile::rf_add_t a,
                             input p_regfile::rf_val_t val, input logic ce, input logic uce);
      p_regfile::rf_val_t exp_val;
      logic               exp_uce;
      exp_val = (a == '0) ? '0 : ref_val[a];
      exp_uce = (a != '0) && (nbits(a) >= 2);
      if (!exp_uce) begin   // value undefined after a double error
         n_chk++;
         assert (val === exp_val) else begin
            $display("CHECK FAILED %s_val_o: got %h expected %h", name, val, exp_val);
            n_err++;
         end
      end
      n_chk++;
      assert (ce === ce_expected(a)) else begin
         $display("CHECK FAILED %s_ce_o: got %h expected %h", name, ce, ce_expected(a));
         n_err++;
      end
      n_chk++;
      assert (uce === exp_uce) else begin
         $display("CHECK FAILED %s_uce_o: got %h expected %h", name, uce, exp_uce);
         n_err++;
      end
   endtask

   // check this cycle, advance the model over the edge, return at drive time
   task automatic tick();
      logic req1;
      logic req2;
      logic inj_ok;
      #1;
      check_port("rd1", rd1_add, rd1_val, rd1_ce, rd1_uce);
      check_port("rd2", rd2_add, rd2_val, rd2_ce, rd2_uce);
      req1   = ce_expected(rd1_add) && !file_hit(rd1_add);
      req2   = ce_expected(rd2_add) && !file_hit(rd2_add);
      inj_ok = inj_we && !file_hit(inj_add);   // normal write wins
      if (!wb_we && ref_pend) begin   // repair restores the codeword
         ref_dm[ref_rep_add] = '0;
         ref_cm[ref_rep_add] = '0;
      end
      if (wb_we && wb_add != '0) begin
         ref_val[wb_add] = wb_val;
         ref_dm[wb_add]  = '0;
         ref_cm[wb_add]  = '0;
      end
      if (inj_ok) begin
         ref_dm[inj_add] = ref_dm[inj_add] ^ inj_dmask;
         ref_cm[inj_add] = ref_cm[inj_add] ^ inj_cmask;
      end
      if (ref_pend && wb_we) begin
         ref_pend = (wb_add != ref_rep_add);   // held, or cancelled by wb
      end else begin
         ref_pend = req1 || req2;
         ref_rep_add = req2 ? rd2_add : rd1_add;   // port 2 first
      end
      @(posedge clk);
      #1;
   endtask

   task automatic clear_inputs();
      wb_we     = 1'b0;
      wb_add    = '0;
      wb_val    = '0;
      ma_we     = 1'b0;
      ma_add    = '0;
      ex_we     = 1'b0;
      ex_add    = '0;
      rd1_add   = '0;
      rd2_add   = '0;
      inj_we    = 1'b0;
      inj_add   = '0;
      inj_dmask = '0;
      inj_cmask = '0;
   endtask

   task automatic idle(input int n);
      clear_inputs();
      repeat (n) tick();
   endtask

   task automatic write_reg(input p_regfile::rf_add_t a, input p_regfile::rf_val_t v);
      clear_inputs();
      wb_we  = 1'b1;
      wb_add = a;
      wb_val = v;
      tick();
      clear_inputs();
   endtask

   task automatic inject(input p_regfile::rf_add_t a, input p_regfile::rf_val_t dm,
                         input p_regfile::rf_chk_t cm);
      clear_inputs();
      inj_we    = 1'b1;
      inj_add   = a;
      inj_dmask = dm;
      inj_cmask = cm;
      tick();
      clear_inputs();
   endtask

   task automatic read_regs(input p_regfile::rf_add_t a1, input p_regfile::rf_add_t a2);
      clear_inputs();
      rd1_add = a1;
      rd2_add = a2;
      tick();
      clear_inputs();
   endtask

   function automatic p_regfile::rf_val_t data_flip();   // one random data bit
      return p_regfile::rf_val_t'(32'h1 << rand_bits(5));
   endfunction

   function automatic p_regfile::rf_chk_t chk_flip();   // one random checksum bit
      return p_regfile::rf_chk_t'(7'h1 << (rand_bits(3) % 7));
   endfunction

   initial begin
      #(LIMIT_NS);
      $display("timeout: run still busy after %0d ns", LIMIT_NS);
      $display("checks %0d errors %0d", n_chk, n_err + 1);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      p_regfile::rf_add_t a;
      p_regfile::rf_add_t b;
      int                 bit1;
      int                 bit2;
      lfsr        = 32'd76148;
      n_chk       = 0;
      n_err       = 0;
      ref_pend    = 1'b0;
      ref_rep_add = '0;
      for (int i = 0; i < p_regfile::NREGS; i++) begin
         ref_val[i] = '0;
         ref_dm[i]  = '0;
         ref_cm[i]  = '0;
      end
      clear_inputs();
      wait (rst_n === 1'b1);
      @(posedge clk);
      #1;
      // arrays have no reset, fill every register first
      for (int i = 1; i < p_regfile::NREGS; i++) begin
         write_reg(p_regfile::rf_add_t'(i), rand_bits(32));
      end
      // 1: random traffic on clean registers, x0 included
      for (int i = 0; i < N_RAND; i++) begin
         wb_we   = 1'(rand_bits(1));
         wb_add  = p_regfile::rf_add_t'(rand_bits(5));
         wb_val  = rand_bits(32);
         ex_we   = 1'(rand_bits(1));
         ex_add  = p_regfile::rf_add_t'(rand_bits(5));
         ma_we   = 1'(rand_bits(1));
         ma_add  = p_regfile::rf_add_t'(rand_bits(5));
         rd1_add = p_regfile::rf_add_t'(rand_bits(5));
         rd2_add = p_regfile::rf_add_t'(rand_bits(5));
         tick();
      end
      for (int k = 0; k < N_SCEN; k++) begin
         // 2: single flip, corrected on read, then repaired
         a = rand_reg();
         write_reg(a, rand_bits(32));
         if (k % 2 == 0) begin
            inject(a, data_flip(), '0);
            read_regs(a, '0);
         end else begin
            inject(a, '0, chk_flip());
            read_regs('0, a);
         end
         idle(2);
         read_regs(a, a);
         // 3: both ports faulty, port 2 gets the repair
         a = rand_reg();
         b = (a == 5'd31) ? 5'd1 : a + 5'd1;
         write_reg(a, rand_bits(32));
         write_reg(b, rand_bits(32));
         inject(a, data_flip(), '0);
         inject(b, '0, chk_flip());
         read_regs(a, b);
         idle(2);
         read_regs(a, b);   // a still shows ce
         idle(2);
         // 4: double flip persists
         a = rand_reg();
         write_reg(a, rand_bits(32));
         bit1 = int'(rand_bits(5));
         bit2 = (bit1 + 1 + int'(rand_bits(4))) % 32;
         if (k % 2 == 0) begin
            inject(a, p_regfile::rf_val_t'((32'h1 << bit1) | (32'h1 << bit2)), '0);
         end else begin
            inject(a, p_regfile::rf_val_t'(32'h1 << bit1),
                   p_regfile::rf_chk_t'(7'h1 << (bit2 % 7)));
         end
         read_regs(a, '0);
         idle(2);
         read_regs('0, a);
         write_reg(a, rand_bits(32));   // scrub
         // 5: forwarded operand, no ce and no repair
         a = rand_reg();
         write_reg(a, rand_bits(32));
         inject(a, data_flip(), '0);
         clear_inputs();
         rd1_add = a;
         case (k % 3)
            0: begin
               ex_we  = 1'b1;
               ex_add = a;
            end
            1: begin
               ma_we  = 1'b1;
               ma_add = a;
            end
            default: begin
               wb_we  = 1'b1;   // overwrites the faulty word
               wb_add = a;
               wb_val = rand_bits(32);
            end
         endcase
         tick();
         idle(2);
         read_regs(a, '0);
         idle(2);
         // 6a: writeback in the repair cycle cancels it
         a = rand_reg();
         b = (a == 5'd31) ? 5'd1 : a + 5'd1;
         write_reg(a, rand_bits(32));
         inject(a, '0, chk_flip());
         read_regs(a, '0);
         write_reg(a, rand_bits(32));
         idle(1);
         read_regs(a, a);
         // 6b: writeback elsewhere holds the repair
         write_reg(b, rand_bits(32));
         inject(a, data_flip(), '0);
         read_regs(a, '0);
         write_reg(b, rand_bits(32));
         write_reg(b, rand_bits(32));
         idle(1);
         read_regs(a, b);
      end
      idle(2);
      $display("checks %0d errors %0d", n_chk, n_err);
      if (n_err == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS  = 4,   // clock period
   parameter int RST_CYCLES = 5    // rising edges with reset low
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;   // first rising edge at 2 ns
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      #1 rst_n_o = 1'b1;   // released at the same offset as the stimulus
   end

endmodule

`default_nettype wire

// File: verilog/acm.sv
// automatic correction mechanism
`timescale 1ns/1ps
`default_nettype none

module acm (
   input  logic               s_clk_i,      // core clock
   input  logic               rst_n_i,      // sync reset, active low

   input  logic               wb_we_i,      // writeback writes a register
   input  p_regfile::rf_add_t wb_add_i,     // writeback destination
   input  p_regfile::rf_val_t wb_val_i,     // writeback result
   input  logic               ma_we_i,      // MA stage will write
   input  p_regfile::rf_add_t ma_add_i,
   input  logic               ex_we_i,      // EX stage will write
   input  p_regfile::rf_add_t ex_add_i,

   input  p_regfile::rf_add_t rd1_add_i,    // read port 1 address
   input  p_regfile::rf_add_t rd2_add_i,    // read port 2 address
   input  p_regfile::rf_val_t rd1_dat_i,    // raw data, port 1
   input  p_regfile::rf_val_t rd2_dat_i,
   input  p_regfile::rf_chk_t rd1_chk_i,    // raw checksum, port 1
   input  p_regfile::rf_chk_t rd2_chk_i,

   output p_regfile::rf_val_t rd1_val_o,    // corrected operand
   output p_regfile::rf_val_t rd2_val_o,
   output logic               rd1_ce_o,     // correctable, repair wanted
   output logic               rd2_ce_o,
   output logic               rd1_uce_o,    // uncorrectable
   output logic               rd2_uce_o,

   output logic               file_we_o,    // array write port
   output p_regfile::rf_add_t file_add_o,
   output p_regfile::rf_val_t file_val_o
);

   p_regfile::rf_val_t rd1_dec;       // decoder outputs
   p_regfile::rf_val_t rd2_dec;
   logic               rd1_ce_raw;
   logic               rd2_ce_raw;
   logic               rd1_uce_raw;
   logic               rd2_uce_raw;
   logic               rd1_nz;        // port reads something other than x0
   logic               rd2_nz;
   logic               rd1_fwd;       // operand comes from the pipeline
   logic               rd2_fwd;
   logic               rd1_rep;       // port asks for a repair
   logic               rd2_rep;
   logic               rep_req;       // any new repair request
   logic               rep_hold;      // pending repair blocked by wb
   logic               rep_fix;       // pending repair owns the write port
   logic               rep_pend_d;
   logic               rep_pend_q;    // pending repair flag
   p_regfile::rf_add_t rep_add_q;     // register to repair
   p_regfile::rf_val_t rep_val_q;     // corrected value to write back
   logic               wb_wr;         // writeback with x0 filtered out

   secded_check m_chk1 (
      .data_i (rd1_dat_i),
      .chk_i  (rd1_chk_i),
      .data_o (rd1_dec),
      .ce_o   (rd1_ce_raw),
      .uce_o  (rd1_uce_raw)
   );

   secded_check m_chk2 (
      .data_i (rd2_dat_i),
      .chk_i  (rd2_chk_i),
      .data_o (rd2_dec),
      .ce_o   (rd2_ce_raw),
      .uce_o  (rd2_uce_raw)
   );

   // x0 reads zero and never reports anything
   assign rd1_nz = (rd1_add_i != '0);
   assign rd2_nz = (rd2_add_i != '0);

   assign rd1_val_o = rd1_nz ? rd1_dec : '0;
   assign rd2_val_o = rd2_nz ? rd2_dec : '0;

   assign rd1_uce_o = rd1_uce_raw & rd1_nz;
   assign rd2_uce_o = rd2_uce_raw & rd2_nz;

   // a younger producer will overwrite the register, no need to repair
   assign rd1_fwd = (ex_we_i & (ex_add_i == rd1_add_i)) |
                    (ma_we_i & (ma_add_i == rd1_add_i)) |
                    (wb_we_i & (wb_add_i == rd1_add_i));
   assign rd2_fwd = (ex_we_i & (ex_add_i == rd2_add_i)) |
                    (ma_we_i & (ma_add_i == rd2_add_i)) |
                    (wb_we_i & (wb_add_i == rd2_add_i));

   assign rd1_ce_o = rd1_ce_raw & rd1_nz & ~rd1_fwd;
   assign rd2_ce_o = rd2_ce_raw & rd2_nz & ~rd2_fwd;

   // drop the request when the array is written at that address now
   assign rd1_rep = rd1_ce_o & ~(file_we_o & (file_add_o == rd1_add_i));
   assign rd2_rep = rd2_ce_o & ~(file_we_o & (file_add_o == rd2_add_i));
   assign rep_req = rd1_rep | rd2_rep;

   assign rep_hold = rep_pend_q & wb_we_i;    // wb always goes first
   assign rep_fix  = rep_pend_q & ~wb_we_i;

   always_comb begin
      rep_pend_d = rep_req;   // load, or free after the repair write
      if (rep_hold) begin
         // keep waiting, cancel if wb overwrites the same register
         rep_pend_d = (wb_add_i != rep_add_q);
      end
   end

   always_ff @(posedge s_clk_i) begin
      if (!rst_n_i) begin
         rep_pend_q <= 1'b0;
      end else begin
         rep_pend_q <= rep_pend_d;
      end
   end

   // payload, new requests only when nothing is held
   always_ff @(posedge s_clk_i) begin
      if (rep_req && !rep_hold) begin
         rep_add_q <= rd2_rep ? rd2_add_i : rd1_add_i;   // port 2 first
         rep_val_q <= rd2_rep ? rd2_dec : rd1_dec;
      end
   end

   // single write port shared by writeback and repair
   assign wb_wr      = wb_we_i & (wb_add_i != '0);
   assign file_we_o  = wb_wr | rep_fix;
   assign file_add_o = wb_we_i ? wb_add_i : rep_add_q;
   assign file_val_o = wb_we_i ? wb_val_i : rep_val_q;

endmodule

`default_nettype wire

// File: verilog/p_regfile.sv
// register file sizes and secded code
`default_nettype none

package p_regfile;

   localparam int XLEN  = 32;              // data width
   localparam int CHK_W = 7;               // checksum width
   localparam int NREGS = 32;              // x0..x31
   localparam int ADD_W = $clog2(NREGS);   // register index width

   typedef logic [ADD_W-1:0] rf_add_t;     // register address
   typedef logic [XLEN-1:0]  rf_val_t;     // register value
   typedef logic [CHK_W-1:0] rf_chk_t;     // stored checksum

   // hsiao (39,32) code
   // every data column has weight three and all columns differ,
   // so a single flip gives an odd syndrome and a double flip an even one
   // row j lists the data bits folded into checksum bit j
   localparam rf_val_t SECDED_P0 = 32'h0000_7FFF;   // columns holding bit 0
   localparam rf_val_t SECDED_P1 = 32'h01FF_801F;
   localparam rf_val_t SECDED_P2 = 32'h7E07_81E1;
   localparam rf_val_t SECDED_P3 = 32'h8E38_8E22;
   localparam rf_val_t SECDED_P4 = 32'hB2C9_3244;
   localparam rf_val_t SECDED_P5 = 32'hD552_5488;
   localparam rf_val_t SECDED_P6 = 32'h69A4_6910;   // lightest row, 12 bits

   // same rows indexed by checksum bit, for column lookup in the checker
   localparam rf_val_t [CHK_W-1:0] SECDED_ROWS = {
      SECDED_P6,
      SECDED_P5,
      SECDED_P4,
      SECDED_P3,
      SECDED_P2,
      SECDED_P1,
      SECDED_P0
   };

endpackage

`default_nettype wire

// File: verilog/regfile_ecc.sv
// protected integer register file
`timescale 1ns/1ps
`default_nettype none

module regfile_ecc (
   input  logic               s_clk_i,           // core clock
   input  logic               rst_n_i,           // sync reset, active low

   input  logic               wb_we_i,           // writeback port
   input  p_regfile::rf_add_t wb_add_i,
   input  p_regfile::rf_val_t wb_val_i,
   input  logic               ma_we_i,           // MA destination, forwarding only
   input  p_regfile::rf_add_t ma_add_i,
   input  logic               ex_we_i,           // EX destination, forwarding only
   input  p_regfile::rf_add_t ex_add_i,

   input  p_regfile::rf_add_t rd1_add_i,         // read ports
   input  p_regfile::rf_add_t rd2_add_i,
   output p_regfile::rf_val_t rd1_val_o,
   output p_regfile::rf_val_t rd2_val_o,
   output logic               rd1_ce_o,
   output logic               rd2_ce_o,
   output logic               rd1_uce_o,
   output logic               rd2_uce_o,

   input  logic               inj_we_i,          // fault injection
   input  p_regfile::rf_add_t inj_add_i,
   input  p_regfile::rf_val_t inj_data_mask_i,
   input  p_regfile::rf_chk_t inj_chk_mask_i
);

   logic               file_we;    // write port from the acm
   p_regfile::rf_add_t file_add;
   p_regfile::rf_val_t file_val;
   p_regfile::rf_chk_t file_chk;   // checksum of file_val
   p_regfile::rf_val_t rd1_dat;    // raw array outputs
   p_regfile::rf_val_t rd2_dat;
   p_regfile::rf_chk_t rd1_chk;
   p_regfile::rf_chk_t rd2_chk;

   acm m_acm (
      .s_clk_i    (s_clk_i),
      .rst_n_i    (rst_n_i),
      .wb_we_i    (wb_we_i),
      .wb_add_i   (wb_add_i),
      .wb_val_i   (wb_val_i),
      .ma_we_i    (ma_we_i),
      .ma_add_i   (ma_add_i),
      .ex_we_i    (ex_we_i),
      .ex_add_i   (ex_add_i),
      .rd1_add_i  (rd1_add_i),
      .rd2_add_i  (rd2_add_i),
      .rd1_dat_i  (rd1_dat),
      .rd2_dat_i  (rd2_dat),
      .rd1_chk_i  (rd1_chk),
      .rd2_chk_i  (rd2_chk),
      .rd1_val_o  (rd1_val_o),
      .rd2_val_o  (rd2_val_o),
      .rd1_ce_o   (rd1_ce_o),
      .rd2_ce_o   (rd2_ce_o),
      .rd1_uce_o  (rd1_uce_o),
      .rd2_uce_o  (rd2_uce_o),
      .file_we_o  (file_we),
      .file_add_o (file_add),
      .file_val_o (file_val)
   );

   // checksum follows whatever the acm writes, wb or repair
   secded_encode m_wenc (
      .data_i (file_val),
      .chk_o  (file_chk)
   );

   rf_array #(.W(p_regfile::XLEN)) m_data (
      .s_clk_i    (s_clk_i),
      .we_i       (file_we),
      .wa_i       (file_add),
      .d_i        (file_val),
      .inj_we_i   (inj_we_i),
      .inj_add_i  (inj_add_i),
      .inj_mask_i (inj_data_mask_i),
      .ra1_i      (rd1_add_i),
      .ra2_i      (rd2_add_i),
      .q1_o       (rd1_dat),
      .q2_o       (rd2_dat)
   );

   rf_array #(.W(p_regfile::CHK_W)) m_chk (   // separate checksum array
      .s_clk_i    (s_clk_i),
      .we_i       (file_we),
      .wa_i       (file_add),
      .d_i        (file_chk),
      .inj_we_i   (inj_we_i),
      .inj_add_i  (inj_add_i),
      .inj_mask_i (inj_chk_mask_i),
      .ra1_i      (rd1_add_i),
      .ra2_i      (rd2_add_i),
      .q1_o       (rd1_chk),
      .q2_o       (rd2_chk)
   );

endmodule

`default_nettype wire

// File: verilog/rf_array.sv
// register storage array
`timescale 1ns/1ps
`default_nettype none

module rf_array #(
   parameter int W = 32   // word width, data or checksum
) (
   input  logic                s_clk_i,      // core clock
   input  logic                we_i,         // write enable
   input  p_regfile::rf_add_t  wa_i,         // write address
   input  logic [W-1:0]        d_i,          // write data
   input  logic                inj_we_i,     // fault injection enable
   input  p_regfile::rf_add_t  inj_add_i,    // injected register
   input  logic [W-1:0]        inj_mask_i,   // bits to flip
   input  p_regfile::rf_add_t  ra1_i,        // read address, port 1
   input  p_regfile::rf_add_t  ra2_i,        // read address, port 2
   output logic [W-1:0]        q1_o,         // read data, port 1
   output logic [W-1:0]        q2_o          // read data, port 2
);

   logic [W-1:0] mem [p_regfile::NREGS];   // no reset, tb initializes
   logic         inj_hit;                  // injection allowed this cycle

   // a normal write to the same word takes precedence over injection
   assign inj_hit = inj_we_i & ~(we_i & (wa_i == inj_add_i));

   always_ff @(posedge s_clk_i) begin
      if (we_i) begin
         mem[wa_i] <= d_i;   // wb or repair
      end
      if (inj_hit) begin
         // flip stored bits in place
         mem[inj_add_i] <= mem[inj_add_i] ^ inj_mask_i;
      end
   end

   // asynchronous reads
   // old contents until the closing edge, no write bypass
   assign q1_o = mem[ra1_i];
   assign q2_o = mem[ra2_i];

   // x0 is stored like any other word, zeroing happens in the acm

endmodule

`default_nettype wire

// File: verilog/secded_check.sv
// secded syndrome check and correction
`timescale 1ns/1ps
`default_nettype none

module secded_check (
   input  p_regfile::rf_val_t data_i,   // word as read from the array
   input  p_regfile::rf_chk_t chk_i,    // checksum as read from the array
   output p_regfile::rf_val_t data_o,   // corrected word
   output logic               ce_o,     // single error, corrected
   output logic               uce_o     // double or worse, not corrected
);

   p_regfile::rf_chk_t chk_calc;   // checksum recomputed from data_i
   p_regfile::rf_chk_t syn;        // syndrome
   p_regfile::rf_val_t flip;       // one-hot mask of the faulty data bit
   logic               chk_err;    // syndrome names a checksum bit

   secded_encode m_enc (
      .data_i (data_i),
      .chk_o  (chk_calc)
   );

   assign syn = chk_calc ^ chk_i;   // zero when the codeword is clean

   // compare the syndrome against every data column
   always_comb begin
      p_regfile::rf_chk_t col;
      flip = '0;
      for (int i = 0; i < p_regfile::XLEN; i++) begin
         // column i of the check matrix, gathered from the rows
         for (int j = 0; j < p_regfile::CHK_W; j++) begin
            col[j] = p_regfile::SECDED_ROWS[j][i];
         end
         flip[i] = (syn == col);   // at most one column can match
      end
   end

   // weight one, flip sits in the stored checksum, data is fine
   assign chk_err = $onehot(syn);

   assign data_o = data_i ^ flip;   // repair the data bit if one matched

   assign ce_o = (|flip) | chk_err;

   // anything else nonzero: even weight, or odd weight with no column
   assign uce_o = (syn != '0) & ~ce_o;

endmodule

`default_nettype wire

// File: verilog/secded_encode.sv
// secded checksum encoder
`timescale 1ns/1ps
`default_nettype none

module secded_encode (
   input  p_regfile::rf_val_t data_i,   // word to protect
   output p_regfile::rf_chk_t chk_o     // seven parity bits
);

   // each checksum bit is the parity of its row of the check matrix
   // pure xor trees, no state

   // rows 0..2 carry 15 data bits each
   assign chk_o[0] = ^(data_i & p_regfile::SECDED_P0);
   assign chk_o[1] = ^(data_i & p_regfile::SECDED_P1);
   assign chk_o[2] = ^(data_i & p_regfile::SECDED_P2);

   // rows 3..5 carry 13 bits
   assign chk_o[3] = ^(data_i & p_regfile::SECDED_P3);
   assign chk_o[4] = ^(data_i & p_regfile::SECDED_P4);
   assign chk_o[5] = ^(data_i & p_regfile::SECDED_P5);

   assign chk_o[6] = ^(data_i & p_regfile::SECDED_P6);   // 12 bits

   // used on the write path and inside both read checkers
   // the zero word encodes to a zero checksum

endmodule

`default_nettype wire
